// File: flist.f
hw/trace_pkg.sv
hw/trace_stage_if.sv
hw/trace_retire_if.sv
hw/trace_ex_stage.sv
hw/trace_wb_stage.sv
hw/trace_retire_queue.sv
hw/trace_top.sv
verification/trace_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the retirement tracker testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module trace_tb \
  -f flist.f \
  -o trace_sim

./obj_dir/trace_sim 2>&1 | tee sim.log

if grep -q "All tests passed" sim.log; then
  echo "Simulation run reports success"
else
  echo "Simulation run reports failure"
  exit 1
fi

// File: verification/trace_tests.txt
# pc instr compressed illegal misaligned stage(0 none 1 ex 2 wb) wreg wval ex_stall wb_stall
# exp_rd exp_written exp_value, stall counts of -1 are drawn at random
00001000 00100293 0 0 0 1 05 11111111 0 0 05 1 11111111
00001004 00000333 0 0 0 1 07 22222222 1 0 06 0 00000000
00001008 004003b3 0 0 0 2 07 33333333 0 2 07 1 33333333
0000100c 00000013 0 1 0 0 00 00000000 0 0 00 0 00000000
00001010 0002a403 0 0 1 2 08 44444444 1 0 08 1 44444444
00001014 30200073 0 0 0 0 00 00000000 0 0 00 0 00000000
00001018 00000493 0 0 0 1 09 55555555 0 0 09 1 55555555
0000101c 00009002 1 0 0 0 00 00000000 0 0 00 0 00000000
0000101e 00000513 0 0 0 2 0a 66666666 0 0 0a 1 66666666
00001022 00000593 0 0 0 1 0b 77777777 -1 -1 0b 1 77777777
00001026 0000a603 0 0 1 2 0c 88888888 -1 -1 0c 1 88888888
0000102a 00100073 0 0 0 0 00 00000000 -1 0 00 0 00000000
0000102e 00000693 0 0 0 2 0e 99999999 -1 -1 0d 0 00000000
00001032 00200073 0 0 0 0 00 00000000 0 0 00 0 00000000
00001036 00000713 0 0 0 1 0e aaaaaaaa -1 -1 0e 1 aaaaaaaa
0000103a ffffffff 0 1 0 0 00 00000000 0 0 00 0 00000000
0000103e 0000a793 0 0 1 1 0f bbbbbbbb -1 -1 0f 1 bbbbbbbb
00001042 0000a803 0 0 1 2 11 cccccccc 0 1 10 0 00000000

// File: verification/trace_tb.sv
// Testbench that replays the test file through the retirement tracker and checks retirements in order
`timescale 1ns/1ns

module trace_tb;
  import trace_pkg::*;

  logic                  clk_i;
  logic                  rst_n;
  logic [XLEN-1:0]       pc_i;
  logic [XLEN-1:0]       instr_i;
  logic                  compressed_i;
  logic                  id_valid_i;
  logic                  is_decoding_i;
  logic                  is_illegal_i;
  logic                  ex_valid_i;
  logic                  data_misaligned_i;
  logic                  ex_reg_we_i;
  logic [REG_ADDR_W-1:0] ex_reg_addr_i;
  logic [XLEN-1:0]       ex_reg_wdata_i;
  logic                  wb_valid_i;
  logic                  wb_reg_we_i;
  logic [REG_ADDR_W-1:0] wb_reg_addr_i;
  logic [XLEN-1:0]       wb_reg_wdata_i;
  logic                  retire_valid_o;
  logic [XLEN-1:0]       retire_pc_o;
  logic [XLEN-1:0]       retire_instr_o;
  logic                  retire_compressed_o;
  logic [REG_ADDR_W-1:0] retire_rd_o;
  logic                  retire_rd_written_o;
  logic [XLEN-1:0]       retire_rd_value_o;

  string                 lines_q [$];
  trace_rec_t            exp_q [$];
  integer                seed;
  int                    errors;
  int                    retired_cnt;
  int                    legal_cnt;
  bit                    loaded;

  // Writeback retire of the previous instruction goes out with the next decode
  logic                  pend_valid;
  logic                  pend_we;
  logic [REG_ADDR_W-1:0] pend_addr;
  logic [XLEN-1:0]       pend_data;

  trace_top u_trace_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic clear_strobes();
    id_valid_i        = 1'b0;
    is_decoding_i     = 1'b0;
    is_illegal_i      = 1'b0;
    ex_valid_i        = 1'b0;
    data_misaligned_i = 1'b0;
    ex_reg_we_i       = 1'b0;
    ex_reg_addr_i     = '0;
    ex_reg_wdata_i    = '0;
    wb_valid_i        = 1'b0;
    wb_reg_we_i       = 1'b0;
    wb_reg_addr_i     = '0;
    wb_reg_wdata_i    = '0;
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
    clear_strobes();
  endtask

  task automatic release_pending();
    if (pend_valid) begin
      wb_valid_i     = 1'b1;
      wb_reg_we_i    = pend_we;
      wb_reg_addr_i  = pend_addr;
      wb_reg_wdata_i = pend_data;
      pend_valid     = 1'b0;
    end
  endtask

  // ------------------------------------------------------------------
  // One instruction from decode to the cycle before its writeback retire
  // ------------------------------------------------------------------
  task automatic run_line(input string line);
    logic [XLEN-1:0] f_pc, f_instr, f_val, f_exp;
    logic [XLEN-1:0] f_comp, f_ill, f_mis, f_stage, f_reg, f_rd, f_wr;
    int              ex_stall, wb_stall, n;
    trace_rec_t      exp_rec;
    n = $sscanf(line, "%h %h %h %h %h %h %h %h %d %d %h %h %h", f_pc, f_instr, f_comp,
                f_ill, f_mis, f_stage, f_reg, f_val, ex_stall, wb_stall, f_rd, f_wr, f_exp);
    if (n != 13) begin
      errors++;
      $display("Test line could not be parsed: %s", line);
      return;
    end
    if (ex_stall < 0) ex_stall = $unsigned($random(seed)) % 4;
    if (wb_stall < 0) wb_stall = $unsigned($random(seed)) % 4;
    pc_i          = f_pc;
    instr_i       = f_instr;
    compressed_i  = f_comp[0];
    id_valid_i    = 1'b1;
    is_decoding_i = 1'b1;
    is_illegal_i  = f_ill[0];
    release_pending();
    if (!f_ill[0]) begin
      exp_rec            = '0;
      exp_rec.pc         = f_pc;
      exp_rec.instr      = f_instr;
      exp_rec.compressed = f_comp[0];
      exp_rec.rd         = f_rd[REG_ADDR_W-1:0];
      exp_rec.rd_written = f_wr[0];
      exp_rec.rd_value   = f_exp;
      exp_q.push_back(exp_rec);
      legal_cnt++;
    end
    next_cycle();
    if (f_ill[0]) return;
    repeat (ex_stall) next_cycle();
    if (f_mis[0]) begin
      ex_valid_i        = 1'b1;
      data_misaligned_i = 1'b1;
      next_cycle();
    end
    ex_valid_i = 1'b1;
    if (f_stage == 1) begin
      ex_reg_we_i    = 1'b1;
      ex_reg_addr_i  = f_reg[REG_ADDR_W-1:0];
      ex_reg_wdata_i = f_val;
    end else if (f_stage == 2 && f_mis[0]) begin
      // Load data of a held access comes in while writeback is empty
      wb_reg_we_i    = 1'b1;
      wb_reg_addr_i  = f_reg[REG_ADDR_W-1:0];
      wb_reg_wdata_i = f_val;
    end
    next_cycle();
    repeat (wb_stall) next_cycle();
    pend_valid = 1'b1;
    pend_we    = (f_stage == 2) && !f_mis[0];
    pend_addr  = f_reg[REG_ADDR_W-1:0];
    pend_data  = f_val;
  endtask

  task automatic compare_field(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("** Error: %s is %h, expected %h", name, got, exp);
    end
  endtask

  // Retirement stream checked against the expected records in order
  always @(negedge clk_i) begin : retire_monitor
    trace_rec_t exp_rec;
    if (rst_n && retire_valid_o) begin
      retired_cnt++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Retirement at pc %h with no instruction outstanding", retire_pc_o);
      end else begin
        exp_rec = exp_q.pop_front();
        compare_field("retire_pc_o", retire_pc_o, exp_rec.pc);
        compare_field("retire_instr_o", retire_instr_o, exp_rec.instr);
        compare_field("retire_compressed_o", XLEN'(retire_compressed_o),
                      XLEN'(exp_rec.compressed));
        compare_field("retire_rd_o", XLEN'(retire_rd_o), XLEN'(exp_rec.rd));
        compare_field("retire_rd_written_o", XLEN'(retire_rd_written_o),
                      XLEN'(exp_rec.rd_written));
        compare_field("retire_rd_value_o", retire_rd_value_o, exp_rec.rd_value);
      end
    end
  end

  initial begin : watchdog
    wait (loaded);
    repeat ((lines_q.size() + 2) * 40) @(posedge clk_i);
    $display("Timeout: only %0d of %0d instructions retired", retired_cnt, legal_cnt);
    $display("Retired %0d of %0d, errors %0d", retired_cnt, legal_cnt, errors + 1);
    $display("Some tests failed");
    $finish;
  end

  initial begin : main
    int    fd;
    string line;
    seed        = 32'ha4b17795;
    errors      = 0;
    retired_cnt = 0;
    legal_cnt   = 0;
    loaded      = 1'b0;
    pend_valid  = 1'b0;
    pend_we     = 1'b0;
    pend_addr   = '0;
    pend_data   = '0;
    rst_n       = 1'b0;
    pc_i        = '0;
    instr_i     = '0;
    compressed_i = 1'b0;
    clear_strobes();
    fd = $fopen("verification/trace_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Test file could not be opened");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) begin
          if (line.len() > 1 && line.getc(0) != "#") lines_q.push_back(line);
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n = 1'b1;
    // Quiet stretch after reset where no retirement may appear
    repeat (5) next_cycle();
    foreach (lines_q[i]) run_line(lines_q[i]);
    release_pending();
    next_cycle();
    while (retired_cnt < legal_cnt) next_cycle();
    repeat (6) next_cycle();
    if (retired_cnt != legal_cnt || exp_q.size() != 0) begin
      errors++;
      $display("Retired %0d records for %0d legal instructions", retired_cnt, legal_cnt);
    end
    $display("Retired %0d of %0d, errors %0d", retired_cnt, legal_cnt, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: hw/trace_top.sv
// Top level of the retirement tracker, core strobes in and one retired record per cycle out
`timescale 1ns/1ns

module trace_top (
  input  logic                                clk_i,
  input  logic                                rst_n,
  input  logic [trace_pkg::XLEN-1:0]          pc_i,
  input  logic [trace_pkg::XLEN-1:0]          instr_i,
  input  logic                                compressed_i,
  input  logic                                id_valid_i,
  input  logic                                is_decoding_i,
  input  logic                                is_illegal_i,
  input  logic                                ex_valid_i,
  input  logic                                data_misaligned_i,
  input  logic                                ex_reg_we_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0]    ex_reg_addr_i,
  input  logic [trace_pkg::XLEN-1:0]          ex_reg_wdata_i,
  input  logic                                wb_valid_i,
  input  logic                                wb_reg_we_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0]    wb_reg_addr_i,
  input  logic [trace_pkg::XLEN-1:0]          wb_reg_wdata_i,
  output logic                                retire_valid_o,
  output logic [trace_pkg::XLEN-1:0]          retire_pc_o,
  output logic [trace_pkg::XLEN-1:0]          retire_instr_o,
  output logic                                retire_compressed_o,
  output logic [trace_pkg::REG_ADDR_W-1:0]    retire_rd_o,
  output logic                                retire_rd_written_o,
  output logic [trace_pkg::XLEN-1:0]          retire_rd_value_o
);
  import trace_pkg::*;

  trace_rec_t retire_rec;

  trace_stage_if  stage_if ();
  trace_retire_if retire_if ();

  // ------------------------------------------------------------------
  // Pipeline of records
  // ------------------------------------------------------------------
  trace_ex_stage u_ex (
    .clk_i             (clk_i),
    .rst_n             (rst_n),
    .pc_i              (pc_i),
    .instr_i           (instr_i),
    .compressed_i      (compressed_i),
    .id_valid_i        (id_valid_i),
    .is_decoding_i     (is_decoding_i),
    .is_illegal_i      (is_illegal_i),
    .ex_valid_i        (ex_valid_i),
    .data_misaligned_i (data_misaligned_i),
    .ex_reg_we_i       (ex_reg_we_i),
    .ex_reg_addr_i     (ex_reg_addr_i),
    .ex_reg_wdata_i    (ex_reg_wdata_i),
    .wb_reg_we_i       (wb_reg_we_i),
    .wb_reg_addr_i     (wb_reg_addr_i),
    .wb_reg_wdata_i    (wb_reg_wdata_i),
    .stage_o           (stage_if.ex)
  );

  trace_wb_stage u_wb (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .wb_valid_i     (wb_valid_i),
    .wb_reg_we_i    (wb_reg_we_i),
    .wb_reg_addr_i  (wb_reg_addr_i),
    .wb_reg_wdata_i (wb_reg_wdata_i),
    .stage_i        (stage_if.wb),
    .retire_o       (retire_if.wb)
  );

  trace_retire_queue u_queue (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .retire_i       (retire_if.queue),
    .retire_valid_o (retire_valid_o),
    .retire_rec_o   (retire_rec)
  );

  // Record fields out as plain ports
  assign retire_pc_o         = retire_rec.pc;
  assign retire_instr_o      = retire_rec.instr;
  assign retire_compressed_o = retire_rec.compressed;
  assign retire_rd_o         = retire_rec.rd;
  assign retire_rd_written_o = retire_rec.rd_written;
  assign retire_rd_value_o   = retire_rec.rd_value;

endmodule

// File: hw/trace_retire_queue.sv
// Circular retire buffer with two write lanes and one registered output per cycle
`timescale 1ns/1ns

module trace_retire_queue (
  input  logic                  clk_i,
  input  logic                  rst_n,
  trace_retire_if.queue         retire_i,
  output logic                  retire_valid_o,
  output trace_pkg::trace_rec_t retire_rec_o
);
  import trace_pkg::*;

  trace_rec_t              mem_q [RETIRE_DEPTH];
  logic [RETIRE_PTR_W-1:0] wr_ptr_q;
  logic [RETIRE_PTR_W-1:0] rd_ptr_q;
  logic [RETIRE_CNT_W-1:0] count_q;
  logic [RETIRE_PTR_W-1:0] young_ptr;
  logic [1:0]              wr_num;
  logic                    rd_en;

  assign rd_en     = (count_q != '0);
  assign wr_num    = {1'b0, retire_i.old_valid} + {1'b0, retire_i.young_valid};
  // Young lands behind old when both arrive together
  assign young_ptr = retire_i.old_valid ? wr_ptr_q + 1'b1 : wr_ptr_q;

  // ------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (retire_i.old_valid) begin
      mem_q[wr_ptr_q] <= retire_i.old_rec;
    end
    if (retire_i.young_valid) begin
      mem_q[young_ptr] <= retire_i.young_rec;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + RETIRE_PTR_W'(wr_num);
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + RETIRE_CNT_W'(wr_num) - RETIRE_CNT_W'(rd_en);
    end
  end

  // ------------------------------------------------------------------
  // Registered output, one record per cycle
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= rd_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      retire_rec_o <= mem_q[rd_ptr_q];
    end
  end

  // Source pacing keeps the occupancy within the buffer
  assert property (@(posedge clk_i) disable iff (!rst_n)
    (int'(count_q) + int'(wr_num) - int'(rd_en)) <= RETIRE_DEPTH);

endmodule

// File: hw/trace_wb_stage.sv
// Writeback stage with a one-entry delay slot that turns records into retire strobes
`timescale 1ns/1ns

module trace_wb_stage (
  input  logic                                clk_i,
  input  logic                                rst_n,
  input  logic                                wb_valid_i,
  input  logic                                wb_reg_we_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0]    wb_reg_addr_i,
  input  logic [trace_pkg::XLEN-1:0]          wb_reg_wdata_i,
  trace_stage_if.wb                           stage_i,
  trace_retire_if.wb                          retire_o
);
  import trace_pkg::*;

  logic       wb_full_q;
  trace_rec_t wb_rec_q;
  trace_rec_t wb_upd;
  logic       dly_full_q;
  trace_rec_t dly_rec_q;
  logic       wb_hit;
  logic       retire_now;

  // ------------------------------------------------------------------
  // Writeback slot
  // ------------------------------------------------------------------
  assign wb_hit     = wb_full_q && wb_reg_we_i && (wb_reg_addr_i == wb_rec_q.rd);
  assign retire_now = wb_full_q && wb_valid_i;

  always_comb begin
    wb_upd = wb_rec_q;
    if (wb_hit) begin
      wb_upd.rd_written = 1'b1;
      wb_upd.rd_value   = wb_reg_wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wb_full_q <= 1'b0;
    end else if (stage_i.move) begin
      wb_full_q <= 1'b1;
    end else if (retire_now) begin
      wb_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stage_i.move) begin
      wb_rec_q <= stage_i.rec;
    end else begin
      wb_rec_q <= wb_upd;
    end
  end

  // ------------------------------------------------------------------
  // Delay slot, always empties on the next edge
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      dly_full_q <= 1'b0;
    end else begin
      dly_full_q <= retire_now && wb_upd.delay_retire;
    end
  end

  always_ff @(posedge clk_i) begin
    dly_rec_q <= wb_upd;
  end

  // Writeback claims writeback-port writes while it holds a record
  assign stage_i.wb_occupied    = wb_full_q;
  assign stage_i.wb_takes_write = wb_full_q && wb_reg_we_i;

  // Delay slot record is older than the one retiring from writeback
  assign retire_o.old_valid   = dly_full_q;
  assign retire_o.old_rec     = dly_rec_q;
  assign retire_o.young_valid = retire_now && !wb_upd.delay_retire;
  assign retire_o.young_rec   = wb_upd;

  // Execute hands over only when writeback is free or retiring
  assert property (@(posedge clk_i) disable iff (!rst_n)
    stage_i.move |-> !wb_full_q || wb_valid_i);

  assert property (@(posedge clk_i) disable iff (!rst_n) wb_valid_i |-> wb_full_q);

endmodule

// File: hw/trace_ex_stage.sv
// Execute stage that opens a record per legal decode and collects its register writes
`timescale 1ns/1ns

module trace_ex_stage (
  input  logic                                clk_i,
  input  logic                                rst_n,
  input  logic [trace_pkg::XLEN-1:0]          pc_i,
  input  logic [trace_pkg::XLEN-1:0]          instr_i,
  input  logic                                compressed_i,
  input  logic                                id_valid_i,
  input  logic                                is_decoding_i,
  input  logic                                is_illegal_i,
  input  logic                                ex_valid_i,
  input  logic                                data_misaligned_i,
  input  logic                                ex_reg_we_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0]    ex_reg_addr_i,
  input  logic [trace_pkg::XLEN-1:0]          ex_reg_wdata_i,
  input  logic                                wb_reg_we_i,
  input  logic [trace_pkg::REG_ADDR_W-1:0]    wb_reg_addr_i,
  input  logic [trace_pkg::XLEN-1:0]          wb_reg_wdata_i,
  trace_stage_if.ex                           stage_o
);
  import trace_pkg::*;

  logic       ex_full_q;
  trace_rec_t rec_q;
  trace_rec_t rec_new;
  trace_rec_t rec_upd;
  logic       create;
  logic       hold_misaligned;
  logic       leave;
  logic       is_delay_instr;
  logic       ex_hit;
  logic       wb_hit;

  assign create          = id_valid_i && is_decoding_i && !is_illegal_i;
  assign hold_misaligned = ex_full_q && ex_valid_i && data_misaligned_i;
  assign leave           = ex_full_q && ex_valid_i && !data_misaligned_i;

  // Returns and breakpoints retire one cycle late
  assign is_delay_instr = (instr_i == INSTR_MRET) || (instr_i == INSTR_URET) ||
                          (instr_i == INSTR_EBREAK) ||
                          (compressed_i && (instr_i[15:0] == INSTR_C_EBREAK));

  always_comb begin
    rec_new              = '0;
    rec_new.pc           = pc_i;
    rec_new.instr        = instr_i;
    rec_new.compressed   = compressed_i;
    rec_new.rd           = instr_i[11:7];
    rec_new.delay_retire = is_delay_instr;
  end

  // ------------------------------------------------------------------
  // Register write capture
  // ------------------------------------------------------------------
  assign ex_hit = ex_full_q && ex_reg_we_i && (ex_reg_addr_i == rec_q.rd);

  // A held misaligned access gets its load data through the writeback port
  assign wb_hit = ex_full_q && rec_q.misaligned && wb_reg_we_i &&
                  !stage_o.wb_takes_write && (wb_reg_addr_i == rec_q.rd);

  always_comb begin
    rec_upd = rec_q;
    if (ex_hit) begin
      rec_upd.rd_written = 1'b1;
      rec_upd.rd_value   = ex_reg_wdata_i;
    end
    if (wb_hit) begin
      rec_upd.rd_written = 1'b1;
      rec_upd.rd_value   = wb_reg_wdata_i;
    end
    if (hold_misaligned) begin
      rec_upd.misaligned = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ex_full_q <= 1'b0;
    end else if (create) begin
      ex_full_q <= 1'b1;
    end else if (leave) begin
      ex_full_q <= 1'b0;
    end
  end

  // A new decode replaces the leaving record on the same edge
  always_ff @(posedge clk_i) begin
    if (create) begin
      rec_q <= rec_new;
    end else begin
      rec_q <= rec_upd;
    end
  end

  assign stage_o.move = leave;
  assign stage_o.rec  = rec_upd;

  // Execute writes always belong to the record held here
  assert property (@(posedge clk_i) disable iff (!rst_n) ex_reg_we_i |-> ex_full_q);

  // Every writeback write has an owner in writeback or a misaligned record here
  assert property (@(posedge clk_i) disable iff (!rst_n)
    wb_reg_we_i |-> stage_o.wb_occupied || (ex_full_q && rec_q.misaligned));

endmodule

// File: hw/trace_retire_if.sv
// Carries up to two retiring records per cycle from writeback into the retire queue
`timescale 1ns/1ns

interface trace_retire_if;
  import trace_pkg::*;

  // Older record, leaving the delay slot
  logic       old_valid;
  trace_rec_t old_rec;

  // Younger record, leaving writeback directly
  logic       young_valid;
  trace_rec_t young_rec;

  modport wb (
    output old_valid,
    output old_rec,
    output young_valid,
    output young_rec
  );

  modport queue (
    input  old_valid,
    input  old_rec,
    input  young_valid,
    input  young_rec
  );

endinterface

// File: hw/trace_stage_if.sv
// Hands one instruction record from the execute stage to the writeback stage
`timescale 1ns/1ns

interface trace_stage_if;
  import trace_pkg::*;

  // Record leaves execute on the edge that ends this pulse
  logic       move;
  trace_rec_t rec;

  // Writeback status seen by execute
  logic       wb_occupied;
  logic       wb_takes_write;

  modport ex (
    output move,
    output rec,
    input  wb_occupied,
    input  wb_takes_write
  );

  modport wb (
    input  move,
    input  rec,
    output wb_occupied,
    output wb_takes_write
  );

endinterface

// File: hw/trace_pkg.sv
// Record type, widths and opcode constants shared by every block of the retirement tracker
package trace_pkg;

  // Data and register address widths
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // Retire queue geometry, depth kept a power of two so pointers wrap naturally
  localparam int RETIRE_DEPTH = 4;
  localparam int RETIRE_PTR_W = $clog2(RETIRE_DEPTH);
  localparam int RETIRE_CNT_W = $clog2(RETIRE_DEPTH + 1);

  // ------------------------------------------------------------------
  // Instructions that need one extra retire cycle
  // ------------------------------------------------------------------
  localparam logic [31:0] INSTR_MRET     = 32'h3020_0073;
  localparam logic [31:0] INSTR_URET     = 32'h0020_0073;
  localparam logic [31:0] INSTR_EBREAK   = 32'h0010_0073;
  localparam logic [15:0] INSTR_C_EBREAK = 16'h9002;

  // One instruction in flight
  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       instr;
    logic                  compressed;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rd_written;
    logic [XLEN-1:0]       rd_value;
    logic                  delay_retire;
    logic                  misaligned;
  } trace_rec_t;

endpackage
